// File: all.f
verilog/icache_pkg.sv
verilog/cache_line_if.sv
verilog/mem_req_if.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/wb_fill_master.sv
verilog/icache_top.sv
sim/icache_chk.sv
sim/icache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = icache_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    logic [31:0] cpu_addr;
    logic        cpu_flush;
    logic        cpu_ready;
    logic [31:0] cpu_data;
    logic [31:0] wb_adr;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    logic [31:0] rng;
    logic [1:0]  wait_left;
    logic        mem_busy;
    logic [31:0] last_adr;    // address of the last completed bus read
    int          reads_done;
    logic [15:0] ref_valid;
    logic [25:0] ref_tag [16];
    int          errors;
    int          tests_run;
    int          tests_failed;

    icache_top dut_i
    (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_addr  (cpu_addr),
        .cpu_flush (cpu_flush),
        .cpu_ready (cpu_ready),
        .cpu_data  (cpu_data),
        .wb_adr    (wb_adr),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory answers each read after 0 to 3 wait states
    always @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            mem_busy = 1'b0;
        end
        else if (wb_ack)
        begin
            wb_ack <= 1'b0;
            reads_done <= reads_done + 1;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                rng = lcg_next(rng);
                wait_left = rng[17:16];
                if (wb_we !== 1'b0)
                begin
                    $display("ERR wb_we: got %h, expected %h (address %h)",
                             wb_we, 1'b0, wb_adr);
                    errors++;
                end
            end
            if (wait_left == 2'd0)
            begin
                wb_ack <= 1'b1;
                wb_rdata <= wb_adr ^ 32'h5a5a_0000;
                last_adr <= wb_adr;
                mem_busy = 1'b0;
            end
            else
            begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    task automatic fetch(input logic [31:0] addr);
        logic [3:0]  idx;
        logic [25:0] tag;
        logic        exp_hit;
        logic [31:0] exp_data;
        int          start_reads;
        int          cycles;
        idx = addr[5:2];
        tag = addr[31:6];
        exp_hit = ref_valid[idx] && (ref_tag[idx] == tag);
        exp_data = {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
        start_reads = reads_done;
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_addr <= addr;
        @(negedge clk);
        cycles = 1;
        while (!cpu_ready && cycles < 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!cpu_ready)
        begin
            $display("timeout waiting for cpu_ready on address %h", addr);
            errors++;
        end
        else
        begin
            if (cpu_data !== exp_data)
            begin
                $display("ERR cpu_data: got %h, expected %h (address %h)",
                         cpu_data, exp_data, addr);
                errors++;
            end
            if (exp_hit && cycles != 2)
            begin
                $display("hit on address %h answered %0d cycles after acceptance",
                         addr, cycles - 1);
                errors++;
            end
            if (reads_done - start_reads != (exp_hit ? 0 : 1))
            begin
                $display("address %h caused %0d bus reads, expected %0d", addr,
                         reads_done - start_reads, exp_hit ? 0 : 1);
                errors++;
            end
            if (!exp_hit && last_adr !== {addr[31:2], 2'b00})
            begin
                $display("ERR wb_adr: got %h, expected %h", last_adr, {addr[31:2], 2'b00});
                errors++;
            end
        end
        @(posedge clk);
        cpu_valid <= 1'b0;
        ref_valid[idx] = 1'b1;
        ref_tag[idx] = tag;
    endtask

    task automatic flush_cache();
        @(posedge clk);
        cpu_flush <= 1'b1;
        @(posedge clk);
        cpu_flush <= 1'b0;
        ref_valid = '0;
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before)
        begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - errors_before);
        end
        else
        begin
            $display("test %-12s ok", name);
        end
    endtask

    task automatic cold_misses();
        int e;
        e = errors;
        fetch(32'h0000_0100);
        fetch(32'h0000_0104);
        fetch(32'h0000_023c);
        fetch(32'h1000_0012); // byte offset is ignored
        close_test("cold_miss", e);
    endtask

    task automatic refetch_hits();
        int e;
        e = errors;
        fetch(32'h0000_0100);
        fetch(32'h0000_0104);
        fetch(32'h0000_023c);
        fetch(32'h1000_0010);
        close_test("hit", e);
    endtask

    task automatic conflict_eviction();
        int e;
        e = errors;
        fetch(32'h0000_0140); // same index as 0x100, other tag
        fetch(32'h0000_0100);
        fetch(32'h0000_0100);
        close_test("conflict", e);
    endtask

    task automatic flush_then_miss();
        int e;
        e = errors;
        flush_cache();
        fetch(32'h0000_0100);
        fetch(32'h0000_0104);
        fetch(32'h0000_023c);
        fetch(32'h1000_0010);
        close_test("flush", e);
    endtask

    task automatic random_fetches();
        int e;
        e = errors;
        for (int i = 0; i < 200; i++)
        begin
            rng = lcg_next(rng); // bus is idle here, so the memory model draws nothing
            fetch(32'h0000_1000 | {24'd0, rng[21:16], rng[25:24]});
        end
        close_test("random", e);
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        cpu_valid = 1'b0;
        cpu_addr = '0;
        cpu_flush = 1'b0;
        wb_ack = 1'b0;
        wb_rdata = '0;
        rng = 32'd99;
        reads_done = 0;
        ref_valid = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cold_misses();
        refetch_hits();
        conflict_eviction();
        flush_then_miss();
        random_fetches();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim/icache_chk.sv
`timescale 1ns/10ps

module icache_chk
(
    input logic                     clk,
    input logic                     rst,
    input logic                     cpu_ready,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_we,
    input logic                     wb_ack,
    input icache_pkg::cache_state_e state
);
    import icache_pkg::*;

    a_read_only: assert property (@(posedge clk) disable iff (rst) !wb_we)
        else $error("wb_we high on the instruction fetch bus");

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // a strobe is held through slave wait states
    a_stb_hold: assert property (@(posedge clk) disable iff (rst) wb_stb && !wb_ack |=> wb_stb)
        else $error("wb_stb dropped before wb_ack");

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst) cpu_ready |=> !cpu_ready)
        else $error("cpu_ready high for two cycles in a row");

    a_hit_no_bus: assert property (@(posedge clk) disable iff (rst)
        (state == st_compare) |-> !(cpu_ready && wb_cyc))
        else $error("cpu_ready and wb_cyc both high in the compare state");

endmodule

bind icache_top icache_chk chk_i
(
    .clk       (clk),
    .rst       (rst),
    .cpu_ready (cpu_ready),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_ack    (wb_ack),
    .state     (ctrl_i.state)
);

// File: verilog/icache_top.sv
`timescale 1ns/10ps

module icache_top
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cpu_valid,
    input  logic [icache_pkg::addr_w-1:0] cpu_addr,
    input  logic                         cpu_flush,
    output logic                         cpu_ready,
    output logic [icache_pkg::data_w-1:0] cpu_data,
    output logic [31:0]                  wb_adr,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    input  logic [31:0]                  wb_rdata,
    input  logic                         wb_ack
);

    cache_line_if line_if();
    mem_req_if    mem_if();

    icache_ctrl ctrl_i
    (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_addr  (cpu_addr),
        .flush_req (cpu_flush),
        .cpu_ready (cpu_ready),
        .cpu_data  (cpu_data),
        .line      (line_if.ctrl),
        .mem       (mem_if.ctrl)
    );

    icache_tag_array tag_i
    (
        .clk  (clk),
        .rst  (rst),
        .line (line_if.tag_array)
    );

    icache_data_array data_i
    (
        .clk  (clk),
        .line (line_if.data_array)
    );

    wb_fill_master wb_i
    (
        .clk      (clk),
        .rst      (rst),
        .mem      (mem_if.master),
        .wb_adr   (wb_adr),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

endmodule

// File: verilog/wb_fill_master.sv
`timescale 1ns/10ps

module wb_fill_master
(
    input  logic        clk,
    input  logic        rst,
    mem_req_if.master   mem,
    output logic [31:0] wb_adr,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    input  logic [31:0] wb_rdata,
    input  logic        wb_ack
);
    import icache_pkg::*;

    wb_state_e   state;
    logic [31:0] adr_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= wb_idle;
        end
        else
        begin
            case (state)
                wb_idle:
                begin
                    if (mem.req)
                    begin
                        state <= wb_busy;
                    end
                end
                wb_busy:
                begin
                    if (wb_ack)
                    begin
                        state <= wb_idle; // cyc and stb low in the next cycle
                    end
                end
                default:
                begin
                    state <= wb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == wb_idle) && mem.req)
        begin
            adr_q <= {mem.addr[31:2], 2'b00};
        end
    end

    assign wb_adr = adr_q;
    assign wb_cyc = (state == wb_busy);
    assign wb_stb = (state == wb_busy);
    assign wb_we  = 1'b0; // reads only

    assign mem.done = (state == wb_busy) && wb_ack;
    assign mem.data = wb_rdata; // sampled by the controller with done

endmodule

// File: verilog/icache_data_array.sv
`timescale 1ns/10ps

module icache_data_array
(
    input  logic             clk,
    cache_line_if.data_array line
);
    import icache_pkg::*;

    logic [data_w-1:0] words [lines];

    always_ff @(posedge clk)
    begin
        if (line.fill)
        begin
            words[line.index] <= line.fill_data;
        end
    end

    assign line.rd_data = words[line.index]; // stale words are masked by the valid bits

endmodule

// File: verilog/icache_tag_array.sv
`timescale 1ns/10ps

module icache_tag_array
(
    input  logic            clk,
    input  logic            rst,
    cache_line_if.tag_array line
);
    import icache_pkg::*;

    logic [lines-1:0] valid;
    logic [tag_w-1:0] tag_mem [lines];

    // valid bits carry the only state that needs clearing
    always_ff @(posedge clk)
    begin
        if (rst || line.flush)
        begin
            valid <= '0;
        end
        else if (line.fill)
        begin
            valid[line.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line.fill)
        begin
            tag_mem[line.index] <= line.tag;
        end
    end

    assign line.hit = valid[line.index] && (tag_mem[line.index] == line.tag);

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cpu_valid,
    input  logic [icache_pkg::addr_w-1:0] cpu_addr,
    input  logic                         flush_req,
    output logic                         cpu_ready,
    output logic [icache_pkg::data_w-1:0] cpu_data,
    cache_line_if.ctrl                   line,
    mem_req_if.ctrl                      mem
);
    import icache_pkg::*;

    cache_state_e        state;
    cache_state_e        state_nxt;
    logic [addr_w-1:2]   addr_q;   // word address of the request in flight
    logic [data_w-1:0]   fill_q;   // word returned by the last line fill
    logic                accept;

    assign accept = (state == st_idle) && cpu_valid && !flush_req;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= cpu_addr[addr_w-1:2];
        end
        if (mem.done)
        begin
            fill_q <= mem.data;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (accept)
                begin
                    state_nxt = st_compare; // flush wins over a fetch
                end
            end
            st_compare:
            begin
                state_nxt = line.hit ? st_idle : st_allocate;
            end
            st_allocate:
            begin
                if (mem.done)
                begin
                    state_nxt = st_done;
                end
            end
            st_done:
            begin
                state_nxt = st_idle;
            end
            default:
            begin
                state_nxt = st_idle;
            end
        endcase
    end

    assign line.index     = addr_q[index_w+1:2];
    assign line.tag       = addr_q[addr_w-1:index_w+2];
    assign line.fill      = (state == st_allocate) && mem.done;
    assign line.fill_data = mem.data;
    assign line.flush     = (state == st_idle) && flush_req;

    assign mem.req  = (state == st_allocate); // drops in the cycle after done
    assign mem.addr = {addr_q, 2'b00};

    assign cpu_ready = ((state == st_compare) && line.hit) || (state == st_done);
    assign cpu_data  = (state == st_done) ? fill_q : line.rd_data;

endmodule

// File: verilog/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;
    import icache_pkg::*;

    logic [addr_w-1:0] addr;
    logic              req;  // held with addr until done
    logic              done; // one cycle pulse, data valid with it
    logic [data_w-1:0] data;

    modport ctrl
    (
        output addr,
        output req,
        input  done,
        input  data
    );

    modport master
    (
        input  addr,
        input  req,
        output done,
        output data
    );

endinterface

// File: verilog/cache_line_if.sv
`timescale 1ns/10ps

interface cache_line_if;
    import icache_pkg::*;

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic               fill;      // one cycle write strobe for tag and data
    logic [data_w-1:0]  fill_data;
    logic               flush;
    logic               hit;       // combinational from index and tag
    logic [data_w-1:0]  rd_data;   // combinational from index

    modport ctrl
    (
        output index,
        output tag,
        output fill,
        output fill_data,
        output flush,
        input  hit,
        input  rd_data
    );

    modport tag_array
    (
        input  index,
        input  tag,
        input  fill,
        input  flush,
        output hit
    );

    modport data_array
    (
        input  index,
        input  fill,
        input  fill_data,
        output rd_data
    );

endinterface

// File: verilog/icache_pkg.sv
package icache_pkg;

    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int index_w = 4;
    localparam int tag_w   = 26; // addr_w minus index and byte offset
    localparam int lines   = 16;

    // cache controller sequence
    typedef enum logic [1:0]
    {
        st_idle,
        st_compare,
        st_allocate,
        st_done
    } cache_state_e;

    // single word bus read
    typedef enum logic
    {
        wb_idle,
        wb_busy
    } wb_state_e;

endpackage
